// ==== Makefile ====
TOP = tb_usb_tx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f usb_tx.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// ==== tb_usb_tx.sv ====
// Table-driven testbench for usb_tx, writes packets over req/ack and decodes them off the line
`timescale 1ns/10ps
`default_nettype none

module tb_usb_tx;
	import usb_tx_pkg::*;

	localparam int clks_per_bit = 4;
	localparam int fifo_depth = 32;
	localparam int num_pkts = 7;
	localparam int max_len = 24;
	localparam int ack_timeout = 5000;
	localparam int idle_timeout = 40000;

	logic clk;
	logic n_rst;
	logic wr_req;
	logic [7:0] wr_data;
	logic wr_last;
	wire wr_ack;
	wire dp;
	wire dm;
	wire busy;
	line_state_t line;

	// Packet table with byte count, all-ones flag for stuffing and wait-for-idle flag
	int pkt_len [num_pkts] = '{1, 5, 9, 13, 3, 24, 24};
	bit pkt_stuffed [num_pkts] = '{0, 0, 1, 0, 0, 0, 0};
	bit pkt_wait_idle [num_pkts] = '{0, 0, 0, 0, 0, 1, 0};
	logic [7:0] pkt_data [num_pkts][max_len];

	integer seed;
	int rx_done;
	int max_ack_wait;
	line_state_t rx_last;
	int rx_cnt;

	usb_tx #(
		.CLKS_PER_BIT(clks_per_bit),
		.FIFO_DEPTH(fifo_depth)
	) uut (
		.clk(clk),
		.n_rst(n_rst),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.wr_ack(wr_ack),
		.dp(dp),
		.dm(dm),
		.line(line),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_failed(input string text);
		$display("%s", text);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		stop_failed($sformatf("FAIL at %0d ns: %s", $time, msg));
	endtask

	task automatic run_error(input string msg);
		stop_failed($sformatf("Simulation stopped at %0d ns because %s", $time, msg));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			value_error($sformatf("%s got %02h expected %02h", what, got, exp));
	endtask

	task automatic check_crc(input crc16_residual_t got, input crc16_residual_t exp,
			input string what);
		if (got !== exp)
			value_error($sformatf("%s got %04h expected %04h", what, got, exp));
	endtask

	task automatic check_line(input line_state_t got, input line_state_t exp, input string what);
		if (got !== exp)
			value_error($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			value_error($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	// Differential pair for a line state, idle drives J
	task automatic check_pair(input line_state_t s);
		check_bit(dp, s == LINE_J || s == LINE_IDLE, $sformatf("dp in %s", s.name()));
		check_bit(dm, s == LINE_K, $sformatf("dm in %s", s.name()));
	endtask

	task automatic build_table();
		integer r;
		for (int p = 0; p < num_pkts; p++)
			for (int i = 0; i < max_len; i++)
				pkt_data[p][i] = 8'h00;
		pkt_data[0][0] = 8'hd2;
		pkt_data[1][0] = 8'hc3;
		pkt_data[1][1] = 8'h01;
		pkt_data[1][2] = 8'h23;
		pkt_data[1][3] = 8'h45;
		pkt_data[1][4] = 8'h67;
		pkt_data[2][0] = 8'h4b;
		for (int i = 1; i < 9; i++)
			pkt_data[2][i] = 8'hff;
		pkt_data[3][0] = 8'hc3;
		for (int i = 1; i < 13; i++) begin
			r = $random(seed);
			pkt_data[3][i] = r[7:0];
		end
		pkt_data[4][0] = 8'h4b;
		pkt_data[4][1] = 8'ha5;
		pkt_data[4][2] = 8'h5a;
		pkt_data[5][0] = 8'hc3;
		pkt_data[6][0] = 8'h4b;
		for (int i = 1; i < max_len; i++) begin
			pkt_data[5][i] = 8'(i * 29 + 7);
			pkt_data[6][i] = 8'(255 - i * 13);
		end
	endtask

	// Reflected CRC16 with seed FFFFh and poly A001h over bytes after the PID, then inverted
	function automatic crc16_residual_t expected_crc(input int p);
		logic [15:0] crc;
		logic fb;
		crc = 16'hffff;
		for (int i = 1; i < pkt_len[p]; i++)
			for (int b = 0; b < 8; b++) begin
				fb = crc[0] ^ pkt_data[p][i][b];
				crc = crc >> 1;
				if (fb)
					crc = crc ^ 16'ha001;
			end
		return ~crc;
	endfunction

	task automatic write_byte(input logic [7:0] data, input logic last);
		int waited;
		@(posedge clk);
		#2;
		wr_data = data;
		wr_last = last;
		wr_req = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > ack_timeout)
				run_error("wr_ack never rose for a host write");
		end while (!wr_ack);
		if (waited > max_ack_wait)
			max_ack_wait = waited;
		wr_req = 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > ack_timeout)
				run_error("wr_ack never fell after the request dropped");
		end while (wr_ack);
	endtask

	task automatic send_all();
		int waited;
		for (int p = 0; p < num_pkts; p++) begin
			if (pkt_wait_idle[p]) begin
				waited = 0;
				while (rx_done < p) begin
					@(posedge clk);
					waited++;
					if (waited > idle_timeout)
						run_error("earlier packets never finished on the line");
				end
				max_ack_wait = 0;
			end
			for (int i = 0; i < pkt_len[p]; i++)
				write_byte(pkt_data[p][i], i == pkt_len[p] - 1);
		end
		// Two long packets back to back overflow the FIFO
		if (max_ack_wait < 2 * clks_per_bit)
			value_error($sformatf("wr_ack not held low in FIFO burst, longest wait %0d",
				max_ack_wait));
	endtask

	// Sample at mid bit with timing restarted at each line change
	task automatic next_sample(output line_state_t s);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 2 * clks_per_bit)
				run_error("the line sampler lost bit timing");
			if (line != rx_last) begin
				rx_last = line;
				rx_cnt = 0;
			end else begin
				rx_cnt++;
			end
		end while (rx_cnt % clks_per_bit != clks_per_bit / 2);
		s = line;
		check_pair(s);
	endtask

	task automatic receive_packet(input int p);
		line_state_t s;
		line_state_t prev;
		logic [7:0] acc;
		logic b;
		logic [7:0] rx_bytes [$];
		int ones;
		int nbits;
		int stuffs;
		int waited;
		crc16_residual_t got_crc;

		waited = 0;
		while (line == LINE_IDLE) begin
			@(negedge clk);
			waited++;
			if (waited > idle_timeout)
				run_error($sformatf("packet %0d never started on the line", p));
		end
		check_line(line, LINE_K, "first SYNC bit");
		check_bit(busy, 1'b1, "busy during SYNC");
		rx_last = line;
		rx_cnt = 0;
		// Idle is J so the first K decodes as zero
		prev = LINE_J;
		acc = 8'h00;
		ones = 0;
		nbits = 0;
		stuffs = 0;
		next_sample(s);
		while (s != LINE_SE0) begin
			if (s != LINE_J && s != LINE_K)
				value_error($sformatf("packet %0d line %s before EOP", p, s.name()));
			b = (s == prev);
			prev = s;
			if (ones == 6) begin
				if (b)
					value_error($sformatf("packet %0d has no stuff bit after six ones", p));
				ones = 0;
				stuffs++;
			end else begin
				ones = b ? ones + 1 : 0;
				acc = {b, acc[7:1]};
				nbits++;
				if (nbits % 8 == 0)
					rx_bytes.push_back(acc);
			end
			if (nbits > (max_len + 3) * 8)
				run_error($sformatf("packet %0d never reached an EOP", p));
			next_sample(s);
		end

		if (nbits % 8 != 0 || rx_bytes.size() != pkt_len[p] + 3)
			value_error($sformatf("packet %0d has %0d bits, expected %0d", p, nbits,
				(pkt_len[p] + 3) * 8));
		check_byte(rx_bytes[0], 8'h80, "SYNC byte");
		for (int i = 0; i < pkt_len[p]; i++)
			check_byte(rx_bytes[i + 1], pkt_data[p][i], $sformatf("packet %0d byte %0d", p, i));
		got_crc = {rx_bytes[pkt_len[p] + 2], rx_bytes[pkt_len[p] + 1]};
		check_crc(got_crc, expected_crc(p), $sformatf("packet %0d CRC16", p));
		if (pkt_stuffed[p] && stuffs == 0)
			value_error($sformatf("packet %0d has no stuff bits", p));

		next_sample(s);
		check_line(s, LINE_SE0, "second EOP bit");
		next_sample(s);
		check_line(s, LINE_J, "EOP J bit");
		waited = 0;
		while (line == LINE_J) begin
			@(negedge clk);
			waited++;
			if (waited > clks_per_bit / 2)
				value_error("EOP J lasted longer than one bit time");
		end
		check_line(line, LINE_IDLE, "line after EOP");
		check_bit(busy, 1'b0, "busy after EOP");
		check_bit(dp, 1'b1, "dp after EOP");
		check_bit(dm, 1'b0, "dm after EOP");
		rx_done = p + 1;
	endtask

	task automatic receive_all();
		for (int p = 0; p < num_pkts; p++)
			receive_packet(p);
	endtask

	initial begin
		n_rst = 1'b0;
		wr_req = 1'b0;
		wr_data = 8'h00;
		wr_last = 1'b0;
		rx_done = 0;
		max_ack_wait = 0;
		seed = 32'h5744_88d3;
		build_table();
		repeat (5) @(posedge clk);
		#2;
		n_rst = 1'b1;

		@(negedge clk);
		check_line(line, LINE_IDLE, "line after reset");
		check_bit(dp, 1'b1, "dp after reset");
		check_bit(dm, 1'b0, "dm after reset");
		check_bit(busy, 1'b0, "busy after reset");
		check_bit(wr_ack, 1'b0, "wr_ack after reset");

		fork
			send_all();
			receive_all();
		join

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== usb_crc16.sv ====
// Serial CRC16 that accumulates data bits, then shifts out the inverted remainder LSB first
`timescale 1ns/10ps
`default_nettype none

module usb_crc16 (
	input wire clk,
	input wire n_rst,
	input wire crc_clear,
	input wire crc_accum,
	input wire crc_enable,
	input wire bit_take,
	input wire data_bit,
	output logic crc_bit,
	output logic crc_sent
);
	import usb_tx_pkg::*;

	crc16_residual_t crc;
	logic [3:0] out_cnt;
	logic feedback;

	assign feedback = crc[0] ^ data_bit;
	assign crc_bit = ~crc[0];
	assign crc_sent = bit_take && crc_enable && (out_cnt == 4'd15);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			crc <= crc16_init;
			out_cnt <= '0;
		end else if (crc_clear) begin
			crc <= crc16_init;
			out_cnt <= '0;
		end else if (bit_take && crc_enable) begin
			// Output mode, remainder just drains toward bit 0
			crc <= {1'b0, crc[15:1]};
			out_cnt <= out_cnt + 1'b1;
		end else if (bit_take && crc_accum) begin
			crc <= {1'b0, crc[15:1]} ^ (feedback ? crc16_poly : 16'h0000);
		end
	end

endmodule

`default_nettype wire

// ==== usb_tx.f ====
usb_tx_pkg.sv
usb_tx_byte_buffer.sv
usb_tx_controller.sv
usb_tx_shifter.sv
usb_crc16.sv
usb_tx_encoder.sv
usb_tx.sv
tb_usb_tx.sv

// ==== usb_tx.sv ====
// Top level of the USB packet transmitter, wiring buffer, FSM, shifter, CRC and encoder
`timescale 1ns/10ps
`default_nettype none

module usb_tx #(
	parameter int CLKS_PER_BIT = 4,
	parameter int FIFO_DEPTH = 32
) (
	input wire clk,
	input wire n_rst,
	input wire wr_req,
	input wire [7:0] wr_data,
	input wire wr_last,
	output wire wr_ack,
	output wire dp,
	output wire dm,
	output usb_tx_pkg::line_state_t line,
	output wire busy
);
	wire read_enable;
	wire [7:0] head_data;
	wire head_last;
	wire pkt_ready;
	wire load_enable;
	wire load_sync;
	wire tx_enable;
	wire crc_enable;
	wire crc_accum;
	wire crc_clear;
	wire create_eop;
	wire byte_sent;
	wire tx_hold;
	wire crc_sent;
	wire eop_done;
	wire bit_take;
	wire tx_bit;
	wire crc_bit;

	usb_tx_byte_buffer #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_buffer (
		.clk(clk),
		.n_rst(n_rst),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.wr_ack(wr_ack),
		.read_enable(read_enable),
		.head_data(head_data),
		.head_last(head_last),
		.pkt_ready(pkt_ready)
	);

	usb_tx_controller u_controller (
		.clk(clk),
		.n_rst(n_rst),
		.pkt_ready(pkt_ready),
		.head_last(head_last),
		.byte_sent(byte_sent),
		.tx_hold(tx_hold),
		.crc_sent(crc_sent),
		.eop_done(eop_done),
		.read_enable(read_enable),
		.load_enable(load_enable),
		.load_sync(load_sync),
		.tx_enable(tx_enable),
		.crc_enable(crc_enable),
		.crc_accum(crc_accum),
		.crc_clear(crc_clear),
		.create_eop(create_eop),
		.busy(busy)
	);

	usb_tx_shifter u_shifter (
		.clk(clk),
		.n_rst(n_rst),
		.load_enable(load_enable),
		.load_sync(load_sync),
		.head_data(head_data),
		.bit_take(bit_take),
		.tx_bit(tx_bit),
		.byte_sent(byte_sent)
	);

	usb_crc16 u_crc (
		.clk(clk),
		.n_rst(n_rst),
		.crc_clear(crc_clear),
		.crc_accum(crc_accum),
		.crc_enable(crc_enable),
		.bit_take(bit_take),
		.data_bit(tx_bit),
		.crc_bit(crc_bit),
		.crc_sent(crc_sent)
	);

	usb_tx_encoder #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_encoder (
		.clk(clk),
		.n_rst(n_rst),
		.tx_enable(tx_enable),
		.crc_enable(crc_enable),
		.tx_bit(tx_bit),
		.crc_bit(crc_bit),
		.create_eop(create_eop),
		.bit_take(bit_take),
		.tx_hold(tx_hold),
		.eop_done(eop_done),
		.line(line),
		.dp(dp),
		.dm(dm)
	);

endmodule

`default_nettype wire

// ==== usb_tx_byte_buffer.sv ====
// Host write port with four-phase req/ack into a byte FIFO that counts complete packets
`timescale 1ns/10ps
`default_nettype none

module usb_tx_byte_buffer #(
	parameter int FIFO_DEPTH = 32
) (
	input wire clk,
	input wire n_rst,
	input wire wr_req,
	input wire [7:0] wr_data,
	input wire wr_last,
	output logic wr_ack,
	input wire read_enable,
	output logic [7:0] head_data,
	output logic head_last,
	output logic pkt_ready
);
	localparam int aw = $clog2(FIFO_DEPTH);

	typedef enum logic {
		ACK_LOW,
		ACK_HIGH
	} ack_state_t;

	ack_state_t ack_state;
	logic [8:0] mem [FIFO_DEPTH];
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;
	logic [aw:0] pkt_cnt;
	logic full;
	logic push;
	logic pkt_in;
	logic pkt_out;

	// Extra pointer bit tells full from empty
	assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
	assign push = (ack_state == ACK_LOW) && wr_req && !full;
	assign pkt_in = push && wr_last;
	assign pkt_out = read_enable && head_last;

	assign wr_ack = (ack_state == ACK_HIGH);
	assign {head_last, head_data} = mem[rd_ptr[aw-1:0]];
	assign pkt_ready = (pkt_cnt != '0);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[aw-1:0]] <= {wr_last, wr_data};
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			ack_state <= ACK_LOW;
			wr_ptr <= '0;
			rd_ptr <= '0;
			pkt_cnt <= '0;
		end else begin
			// Ack stays high until the host drops its request
			if (push)
				ack_state <= ACK_HIGH;
			else if (ack_state == ACK_HIGH && !wr_req)
				ack_state <= ACK_LOW;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (read_enable)
				rd_ptr <= rd_ptr + 1'b1;
			if (pkt_in && !pkt_out)
				pkt_cnt <= pkt_cnt + 1'b1;
			else if (pkt_out && !pkt_in)
				pkt_cnt <= pkt_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== usb_tx_controller.sv ====
// Transmit FSM that sequences SYNC, packet bytes, CRC16 and EOP for each stored packet
`timescale 1ns/10ps
`default_nettype none

module usb_tx_controller (
	input wire clk,
	input wire n_rst,
	input wire pkt_ready,
	input wire head_last,
	input wire byte_sent,
	input wire tx_hold,
	input wire crc_sent,
	input wire eop_done,
	output logic read_enable,
	output logic load_enable,
	output logic load_sync,
	output logic tx_enable,
	output logic crc_enable,
	output logic crc_accum,
	output logic crc_clear,
	output logic create_eop,
	output logic busy
);
	import usb_tx_pkg::*;

	tx_state_t state;
	tx_state_t next_state;
	logic first_byte;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			first_byte <= 1'b0;
		end else begin
			state <= next_state;
			// PID is the first byte and stays out of the CRC
			if (state == SYNC_LOAD)
				first_byte <= 1'b1;
			else if (state == READ)
				first_byte <= 1'b0;
		end
	end

	assign crc_accum = (state == START_TX || state == HOLD_TX) && !first_byte;

	// The READ/LOAD gap between bytes fits in one bit time of four clocks or more
	always_comb begin
		next_state = state;
		read_enable = 1'b0;
		load_enable = 1'b0;
		load_sync = 1'b0;
		tx_enable = 1'b0;
		crc_enable = 1'b0;
		crc_clear = 1'b0;
		create_eop = 1'b0;
		busy = 1'b1;

		case (state)
			IDLE: begin
				busy = 1'b0;
				if (pkt_ready)
					next_state = SYNC_LOAD;
			end
			SYNC_LOAD: begin
				load_sync = 1'b1;
				crc_clear = 1'b1;
				next_state = SYNC_TX;
			end
			SYNC_TX: begin
				tx_enable = 1'b1;
				if (byte_sent)
					next_state = LOAD;
			end
			LOAD: begin
				tx_enable = 1'b1;
				load_enable = 1'b1;
				next_state = START_TX;
			end
			START_TX: begin
				tx_enable = 1'b1;
				if (byte_sent)
					next_state = READ;
				else if (tx_hold)
					next_state = HOLD_TX;
			end
			HOLD_TX: begin
				// Stuff bit on the line, byte may still end on the next tick
				tx_enable = 1'b1;
				if (byte_sent)
					next_state = READ;
				else if (!tx_hold)
					next_state = START_TX;
			end
			READ: begin
				tx_enable = 1'b1;
				read_enable = 1'b1;
				next_state = head_last ? CRC_TX : LOAD;
			end
			CRC_TX: begin
				crc_enable = 1'b1;
				if (crc_sent)
					next_state = CREATE_EOP;
				else if (tx_hold)
					next_state = HOLD_CRC;
			end
			HOLD_CRC: begin
				crc_enable = 1'b1;
				if (crc_sent)
					next_state = CREATE_EOP;
				else if (!tx_hold)
					next_state = CRC_TX;
			end
			CREATE_EOP: begin
				create_eop = 1'b1;
				if (eop_done)
					next_state = IDLE;
			end
			default: begin
				busy = 1'b0;
				next_state = IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== usb_tx_encoder.sv ====
// Bit timing, bit stuffing, NRZI and EOP generation driving the dp/dm pair
`timescale 1ns/10ps
`default_nettype none

module usb_tx_encoder #(
	parameter int CLKS_PER_BIT = 4
) (
	input wire clk,
	input wire n_rst,
	input wire tx_enable,
	input wire crc_enable,
	input wire tx_bit,
	input wire crc_bit,
	input wire create_eop,
	output logic bit_take,
	output logic tx_hold,
	output logic eop_done,
	output usb_tx_pkg::line_state_t line,
	output logic dp,
	output logic dm
);
	import usb_tx_pkg::*;

	localparam int cw = $clog2(CLKS_PER_BIT);
	localparam logic [cw-1:0] last_cnt = cw'(CLKS_PER_BIT - 1);

	logic [cw-1:0] clk_cnt;
	logic [2:0] ones_cnt;
	logic [1:0] eop_cnt;
	logic stuffing;
	logic sending;
	logic tick;
	logic stuff_due;
	logic cur_bit;
	line_state_t toggled;

	assign sending = tx_enable | crc_enable | create_eop;
	assign tick = sending && (clk_cnt == last_cnt);
	assign stuff_due = (ones_cnt == 3'd6);
	assign cur_bit = crc_enable ? crc_bit : tx_bit;
	assign toggled = (line == LINE_K) ? LINE_J : LINE_K;

	assign bit_take = tick && !stuff_due && !create_eop;
	assign eop_done = tick && create_eop && (eop_cnt == 2'd3);
	assign tx_hold = stuffing;

	// Counter waits at zero while idle, so the start latency is fixed
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			clk_cnt <= '0;
		else if (!sending || clk_cnt == last_cnt)
			clk_cnt <= '0;
		else
			clk_cnt <= clk_cnt + 1'b1;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			line <= LINE_IDLE;
			ones_cnt <= '0;
			eop_cnt <= '0;
			stuffing <= 1'b0;
		end else if (tick) begin
			stuffing <= 1'b0;
			if (stuff_due) begin
				// Stuffed zero, also ahead of an EOP
				line <= toggled;
				ones_cnt <= '0;
				stuffing <= 1'b1;
			end else if (create_eop) begin
				ones_cnt <= '0;
				eop_cnt <= eop_cnt + 1'b1;
				case (eop_cnt)
					2'd0, 2'd1: line <= LINE_SE0;
					2'd2: line <= LINE_J;
					default: line <= LINE_IDLE;
				endcase
			end else if (cur_bit) begin
				ones_cnt <= ones_cnt + 1'b1;
			end else begin
				line <= toggled;
				ones_cnt <= '0;
			end
		end
	end

	always_comb begin
		case (line)
			LINE_K: begin
				dp = 1'b0;
				dm = 1'b1;
			end
			LINE_SE0: begin
				dp = 1'b0;
				dm = 1'b0;
			end
			default: begin
				dp = 1'b1;
				dm = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== usb_tx_pkg.sv ====
// Shared constants and enums for the USB packet transmitter, imported by its RTL modules
`default_nettype none

package usb_tx_pkg;

	// SYNC pattern, goes out LSB first as KJKJKJKK
	localparam logic [7:0] sync_byte = 8'h80;

	// CRC16 seed and reflected form of polynomial 8005h
	localparam logic [15:0] crc16_init = 16'hffff;
	localparam logic [15:0] crc16_poly = 16'ha001;

	typedef logic [15:0] crc16_residual_t;

	// Line state on dp/dm, idle is J driven between packets
	typedef enum logic [1:0] {
		LINE_J,
		LINE_K,
		LINE_SE0,
		LINE_IDLE
	} line_state_t;

	// Transmit controller states
	typedef enum logic [3:0] {
		IDLE,
		SYNC_LOAD,
		SYNC_TX,
		LOAD,
		START_TX,
		HOLD_TX,
		READ,
		CRC_TX,
		HOLD_CRC,
		CREATE_EOP
	} tx_state_t;

endpackage

`default_nettype wire

// ==== usb_tx_shifter.sv ====
// Byte shift register feeding the encoder one bit per bit_take, LSB first
`timescale 1ns/10ps
`default_nettype none

module usb_tx_shifter (
	input wire clk,
	input wire n_rst,
	input wire load_enable,
	input wire load_sync,
	input wire [7:0] head_data,
	input wire bit_take,
	output logic tx_bit,
	output logic byte_sent
);
	import usb_tx_pkg::*;

	logic [7:0] shift_reg;
	logic [2:0] bit_cnt;

	assign tx_bit = shift_reg[0];

	// High in the tick cycle of the eighth bit
	assign byte_sent = bit_take && (bit_cnt == 3'd7);

	always_ff @(posedge clk) begin
		if (load_sync)
			shift_reg <= sync_byte;
		else if (load_enable)
			shift_reg <= head_data;
		else if (bit_take)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			bit_cnt <= '0;
		else if (load_sync || load_enable)
			bit_cnt <= '0;
		else if (bit_take)
			bit_cnt <= bit_cnt + 1'b1;
	end

endmodule

`default_nettype wire
